// File: write_bus_pkg.sv
/*
  Bus-side types of the write engine: lane payloads, command fields and widths.
  A beat length is counted in cache lines of line_bytes bytes each.
  The command size field is 12 bits wide, so a beat must stay below 32 lines.
*/

package write_bus_pkg;

	// widths
	parameter int half_width  = 512;
	parameter int addr_width  = 64;
	parameter int lines_width = 32;

	// bytes per cache line, sets the byte size of a command
	parameter int line_bytes = 128;

	// one data half of a 1024-bit write
	typedef logic [half_width-1:0] half_t;

	// lane 0 payload, data half plus where it goes and how long it is
	typedef struct packed {
		half_t                  data;
		logic [addr_width-1:0]  offset;
		logic [lines_width-1:0] lines;
	} write_beat_t;

	////////////////////
	// command fields
	////////////////////

	// write with merge, or write without allocation
	typedef enum logic {
		write_ms = 1'b0,
		write_na = 1'b1
	} write_kind_t;

	// ordering code, passed on unchanged from the configuration word
	typedef logic [2:0] order_code_t;

	// byte size of one command
	typedef logic [11:0] cmd_size_t;

endpackage

// File: write_stream_pkg.sv
/*
  Stream controller definitions: the job FSM states and the width of the
  per-window sent and answered counters.
*/

package write_stream_pkg;

	// per-window counters, also the width of the request limit
	parameter int window_width = 32;

	// job FSM, final is terminal until the next reset
	typedef enum logic [2:0] {
		stream_reset,
		stream_idle,
		stream_start,
		stream_req,
		stream_pending,
		stream_done,
		stream_final
	} stream_state_t;

endpackage

// File: beat_fifo.sv
/*
  Show-ahead FIFO: data_out is the head entry whenever empty is low.
  A push into a full FIFO is dropped and a pop on empty is ignored.
  alfull rises when free entries fall to fifo_headroom.
*/

`timescale 1ns/1ps

module beat_fifo #(
	parameter type payload_t     = logic,
	parameter int  fifo_depth    = 16,
	parameter int  fifo_headroom = 4
) (
	input  logic     clock,
	input  logic     rstn,
	input  logic     push,
	input  payload_t data_in,
	input  logic     pop,
	output payload_t data_out,
	output logic     empty,
	output logic     alfull
);

	localparam int ptr_width   = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int count_width = $clog2(fifo_depth + 1);

	payload_t               mem [fifo_depth];
	logic [ptr_width-1:0]   wr_ptr;
	logic [ptr_width-1:0]   rd_ptr;
	logic [count_width-1:0] count;
	logic                   do_push;
	logic                   do_pop;

	assign do_push = push && (count != count_width'(fifo_depth));
	assign do_pop  = pop && (count != '0);

	assign data_out = mem[rd_ptr];
	assign empty    = (count == '0);
	assign alfull   = (count_width'(fifo_depth) - count) <= count_width'(fifo_headroom);

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	// pointers wrap at fifo_depth, which need not be a power of two
	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == ptr_width'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == ptr_width'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// File: write_engine_config.sv
/*
  Configuration register block. A zero configure word means no change.
  Bits are numbered 0 to 63 from the left: bit 9 picks the command kind,
  bits 5 to 7 carry the ordering code.
*/

`timescale 1ns/1ps

module write_engine_config (
	input  logic                                     clock,
	input  logic                                     rstn,
	input  logic                                     enabled,
	input  logic [0:63]                              configure,
	input  logic [write_stream_pkg::window_width-1:0] max_requests,
	output write_bus_pkg::write_kind_t               kind,
	output write_bus_pkg::order_code_t               order,
	output logic [write_stream_pkg::window_width-1:0] window_limit
);
	import write_bus_pkg::*;

	// keep the last nonzero word, decoded on the way in
	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			kind  <= write_na;
			order <= '0;
		end else if (enabled && (|configure)) begin
			kind  <= configure[9] ? write_ms : write_na;
			order <= configure[5:7];
		end
	end

	// limit may change at any time, taken one cycle late
	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			window_limit <= '0;
		end else begin
			window_limit <= max_requests;
		end
	end

endmodule

// File: write_stream_ctrl.sv
/*
  Job FSM of the write engine. A job is taken only in idle and runs to final,
  which holds until reset. Commands go out in windows of at most window_limit,
  and each window is fully answered before the next one opens.
  A window_limit of zero stalls the job in req and pending forever.
*/

`timescale 1ns/1ps

module write_stream_ctrl (
	input  logic                                     clock,
	input  logic                                     rstn,
	input  logic                                     write_enabled,
	input  logic                                     job_valid,
	input  logic [write_bus_pkg::lines_width-1:0]    job_lines,
	input  logic [write_stream_pkg::window_width-1:0] window_limit,
	input  logic                                     issued,
	input  logic [write_bus_pkg::lines_width-1:0]    issued_lines,
	input  logic                                     resp_seen,
	output logic                                     issue_enable,
	output logic                                     job_done
);
	import write_bus_pkg::*;
	import write_stream_pkg::*;

	stream_state_t           state;
	stream_state_t           next_state;
	logic                    enabled;
	logic                    job_armed;
	logic                    window_open;
	logic [lines_width-1:0]  remaining;
	logic [window_width-1:0] sent;
	logic [window_width-1:0] answered;

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= write_enabled;
		end
	end

	// room left in this window and still something to send
	assign window_open  = (sent < window_limit) && (remaining != '0);
	assign issue_enable = enabled && (state == stream_req) && window_open;
	assign job_done     = (state == stream_final);

	////////////////////
	// state machine
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			state <= stream_reset;
		end else if (enabled) begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			stream_reset: begin
				next_state = stream_idle;
			end
			stream_idle: begin
				if (job_armed) begin
					next_state = stream_start;
				end
			end
			stream_start: begin
				next_state = stream_req;
			end
			stream_req: begin
				if (!window_open) begin
					next_state = stream_pending;
				end
			end
			stream_pending: begin
				if (answered == sent) begin
					next_state = stream_done;
				end
			end
			stream_done: begin
				next_state = (remaining != '0) ? stream_start : stream_final;
			end
			stream_final: begin
				next_state = stream_final;
			end
			default: begin
				next_state = stream_reset;
			end
		endcase
	end

	////////////////////
	// job length
	////////////////////

	// job_valid is registered first, so idle sees it one cycle later
	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			job_armed <= 1'b0;
			remaining <= '0;
		end else begin
			if (job_valid && (state == stream_idle)) begin
				job_armed <= 1'b1;
				remaining <= job_lines;
			end else if (issued) begin
				// a last beat longer than what is left ends the job
				remaining <= (issued_lines >= remaining) ? '0 : remaining - issued_lines;
			end
			if (enabled && (state == stream_idle) && job_armed) begin
				job_armed <= 1'b0;
			end
		end
	end

	////////////////////
	// window counters
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			sent     <= '0;
			answered <= '0;
		end else if (enabled && (state == stream_start)) begin
			sent     <= '0;
			answered <= '0;
		end else begin
			if (issued) begin
				sent <= sent + window_width'(1);
			end
			if (resp_seen) begin
				answered <= answered + window_width'(1);
			end
		end
	end

endmodule

// File: write_command_issue.sv
/*
  Issue stage: pops both lanes together and registers one write command,
  so cmd_valid follows the pop edge by one cycle.
  Responses are latched first and summed one cycle later into done_lines.
  cmd_unit carries the low 8 bits of unit_id.
*/

`timescale 1ns/1ps

module write_command_issue #(
	parameter int unit_id = 3
) (
	input  logic                                  clock,
	input  logic                                  rstn,
	input  logic                                  job_valid,
	input  logic [write_bus_pkg::addr_width-1:0]  job_base,
	input  write_bus_pkg::write_beat_t            beat,
	input  write_bus_pkg::half_t                  half1,
	input  logic                                  lanes_ready,
	input  logic                                  cmd_alfull,
	input  logic                                  issue_enable,
	input  write_bus_pkg::write_kind_t            kind,
	input  write_bus_pkg::order_code_t            order,
	input  logic                                  resp_valid,
	input  logic [write_bus_pkg::lines_width-1:0] resp_lines,
	output logic                                  pop,
	output logic                                  cmd_valid,
	output logic [write_bus_pkg::addr_width-1:0]  cmd_address,
	output write_bus_pkg::cmd_size_t              cmd_size,
	output write_bus_pkg::write_kind_t            cmd_kind,
	output write_bus_pkg::order_code_t            cmd_order,
	output logic [7:0]                            cmd_unit,
	output write_bus_pkg::half_t                  cmd_half0,
	output write_bus_pkg::half_t                  cmd_half1,
	output logic                                  issued,
	output logic [write_bus_pkg::lines_width-1:0] issued_lines,
	output logic                                  resp_seen,
	output logic [write_bus_pkg::lines_width-1:0] done_lines
);
	import write_bus_pkg::*;

	logic [addr_width-1:0]  base;
	logic [lines_width-1:0] resp_lines_q;

	always_ff @(posedge clock) begin
		if (job_valid) begin
			base <= job_base;
		end
	end

	// both heads present, room downstream, window open
	assign pop          = lanes_ready && !cmd_alfull && issue_enable;
	assign issued       = pop;
	assign issued_lines = beat.lines;

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= pop;
		end
	end

	// command fields, valid only alongside cmd_valid
	always_ff @(posedge clock) begin
		if (pop) begin
			cmd_address <= base + beat.offset;
			cmd_size    <= cmd_size_t'(beat.lines * line_bytes);
			cmd_kind    <= kind;
			cmd_order   <= order;
			cmd_unit    <= 8'(unit_id);
			cmd_half0   <= beat.data;
			cmd_half1   <= half1;
		end
	end

	////////////////////
	// responses
	////////////////////

	always_ff @(posedge clock) begin
		resp_lines_q <= resp_lines;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			resp_seen  <= 1'b0;
			done_lines <= '0;
		end else begin
			resp_seen <= resp_valid;
			if (resp_seen) begin
				done_lines <= done_lines + resp_lines_q;
			end
		end
	end

endmodule

// File: write_engine_top.sv
/*
  Write side of the memory engine. Producers must not push while lanes_alfull
  is high; a push into a full lane FIFO is lost.
  Configure bits are numbered 0 to 63 from the left.
  job_valid is taken only while the engine is idle.
*/

`timescale 1ns/1ps

module write_engine_top #(
	parameter int fifo_depth    = 16,
	parameter int fifo_headroom = 4,
	parameter int unit_id       = 3
) (
	input  logic                                     clock,
	input  logic                                     rstn,
	input  logic                                     write_enabled,
	input  logic                                     job_valid,
	input  logic [write_bus_pkg::addr_width-1:0]     job_base,
	input  logic [write_bus_pkg::lines_width-1:0]    job_lines,
	input  logic [0:63]                              configure,
	input  logic [write_stream_pkg::window_width-1:0] max_requests,
	input  logic                                     lane0_push,
	input  write_bus_pkg::write_beat_t               lane0_beat,
	input  logic                                     lane1_push,
	input  write_bus_pkg::half_t                     lane1_half,
	input  logic                                     cmd_alfull,
	input  logic                                     resp_valid,
	input  logic [write_bus_pkg::lines_width-1:0]    resp_lines,
	output logic                                     cmd_valid,
	output logic [write_bus_pkg::addr_width-1:0]     cmd_address,
	output write_bus_pkg::cmd_size_t                 cmd_size,
	output write_bus_pkg::write_kind_t               cmd_kind,
	output write_bus_pkg::order_code_t               cmd_order,
	output logic [7:0]                               cmd_unit,
	output write_bus_pkg::half_t                     cmd_half0,
	output write_bus_pkg::half_t                     cmd_half1,
	output logic                                     lanes_alfull,
	output logic [write_bus_pkg::lines_width-1:0]    done_lines,
	output logic                                     job_done
);
	import write_bus_pkg::*;
	import write_stream_pkg::*;

	write_beat_t             lane0_head;
	half_t                   lane1_head;
	logic                    lane0_empty;
	logic                    lane1_empty;
	logic                    lane0_alfull;
	logic                    lane1_alfull;
	logic                    lanes_ready;
	logic                    pop;
	write_kind_t             kind;
	order_code_t             order;
	logic [window_width-1:0] window_limit;
	logic                    issue_enable;
	logic                    issued;
	logic [lines_width-1:0]  issued_lines;
	logic                    resp_seen;

	assign lanes_alfull = lane0_alfull | lane1_alfull;
	assign lanes_ready  = !lane0_empty && !lane1_empty;

	////////////////////
	// lane buffers
	////////////////////

	// both lanes pop together so the halves stay paired
	beat_fifo #(
		.payload_t    (write_beat_t ),
		.fifo_depth   (fifo_depth   ),
		.fifo_headroom(fifo_headroom)
	) u_lane0_fifo (
		.clock   (clock       ),
		.rstn    (rstn        ),
		.push    (lane0_push  ),
		.data_in (lane0_beat  ),
		.pop     (pop         ),
		.data_out(lane0_head  ),
		.empty   (lane0_empty ),
		.alfull  (lane0_alfull)
	);

	beat_fifo #(
		.payload_t    (half_t       ),
		.fifo_depth   (fifo_depth   ),
		.fifo_headroom(fifo_headroom)
	) u_lane1_fifo (
		.clock   (clock       ),
		.rstn    (rstn        ),
		.push    (lane1_push  ),
		.data_in (lane1_half  ),
		.pop     (pop         ),
		.data_out(lane1_head  ),
		.empty   (lane1_empty ),
		.alfull  (lane1_alfull)
	);

	////////////////////
	// control
	////////////////////

	write_engine_config u_config (
		.clock       (clock        ),
		.rstn        (rstn         ),
		.enabled     (write_enabled),
		.configure   (configure    ),
		.max_requests(max_requests ),
		.kind        (kind         ),
		.order       (order        ),
		.window_limit(window_limit )
	);

	write_stream_ctrl u_stream_ctrl (
		.clock        (clock        ),
		.rstn         (rstn         ),
		.write_enabled(write_enabled),
		.job_valid    (job_valid    ),
		.job_lines    (job_lines    ),
		.window_limit (window_limit ),
		.issued       (issued       ),
		.issued_lines (issued_lines ),
		.resp_seen    (resp_seen    ),
		.issue_enable (issue_enable ),
		.job_done     (job_done     )
	);

	write_command_issue #(
		.unit_id(unit_id)
	) u_issue (
		.clock       (clock       ),
		.rstn        (rstn        ),
		.job_valid   (job_valid   ),
		.job_base    (job_base    ),
		.beat        (lane0_head  ),
		.half1       (lane1_head  ),
		.lanes_ready (lanes_ready ),
		.cmd_alfull  (cmd_alfull  ),
		.issue_enable(issue_enable),
		.kind        (kind        ),
		.order       (order       ),
		.resp_valid  (resp_valid  ),
		.resp_lines  (resp_lines  ),
		.pop         (pop         ),
		.cmd_valid   (cmd_valid   ),
		.cmd_address (cmd_address ),
		.cmd_size    (cmd_size    ),
		.cmd_kind    (cmd_kind    ),
		.cmd_order   (cmd_order   ),
		.cmd_unit    (cmd_unit    ),
		.cmd_half0   (cmd_half0   ),
		.cmd_half1   (cmd_half1   ),
		.issued      (issued      ),
		.issued_lines(issued_lines),
		.resp_seen   (resp_seen   ),
		.done_lines  (done_lines  )
	);

endmodule

// File: write_engine_assertions.sv
/*
  Concurrent checks bound to the write engine top level.
  A push is flagged once lanes_alfull is high, ahead of a lane becoming full.
*/

`timescale 1ns/1ps

module write_engine_assertions (
	input logic clock,
	input logic rstn,
	input logic lane0_push,
	input logic lane1_push,
	input logic lanes_alfull,
	input logic cmd_alfull,
	input logic cmd_valid,
	input logic job_done
);

	// producers stop at almost full, so a full lane never sees a push
	push_while_full: assert property (@(posedge clock) disable iff (!rstn)
		(lane0_push || lane1_push) |-> !lanes_alfull)
		else $error("lane pushed while almost full");

	// back-pressure blocks the pop, so no command one cycle later
	cmd_under_backpressure: assert property (@(posedge clock) disable iff (!rstn)
		cmd_alfull |=> !cmd_valid)
		else $error("command issued after cmd_alfull was high");

	job_done_sticky: assert property (@(posedge clock) disable iff (!rstn)
		job_done |=> job_done)
		else $error("job_done dropped without a reset");

endmodule

bind write_engine_top write_engine_assertions u_assertions (
	.clock       (clock       ),
	.rstn        (rstn        ),
	.lane0_push  (lane0_push  ),
	.lane1_push  (lane1_push  ),
	.lanes_alfull(lanes_alfull),
	.cmd_alfull  (cmd_alfull  ),
	.cmd_valid   (cmd_valid   ),
	.job_done    (job_done    )
);

// File: tb_write_engine.sv
/*
  Testbench for the write engine. Every job row runs after its own reset,
  because the job FSM holds in final until reset.
  Commands are checked in push order against the beats that were pushed.
*/

`timescale 1ns/1ps

module tb_write_engine;
	import write_bus_pkg::*;

	localparam int period   = 8;
	localparam int num_jobs = 4;

	// small lane FIFOs, so the stalled rows reach almost full
	localparam int fifo_depth    = 8;
	localparam int fifo_headroom = 2;

	typedef struct packed {
		logic [63:0]     base;
		logic [0:7][4:0] lengths;
		logic [3:0]      beats;
		logic [63:0]     configure;
		logic [31:0]     max_requests;
		write_kind_t     kind;
		order_code_t     order;
		logic [7:0]      stall;
	} job_row_t;

	// lengths in push order, stall counts cycles of cmd_alfull at job start
	localparam job_row_t jobs [num_jobs] = '{
		'{64'h0000_0000_1000_0000, {5'd1, 5'd2, 5'd3, 5'd1, 5'd4, 5'd2, 5'd0, 5'd0}, 4'd6,
		  64'h0540_0000_0000_0000, 32'd2, write_ms, 3'd5, 8'd0},
		'{64'h0000_0000_2000_4000, {5'd4, 5'd4, 5'd4, 5'd4, 5'd4, 5'd4, 5'd4, 5'd4}, 4'd8,
		  64'h0300_0000_0000_0001, 32'd3, write_na, 3'd3, 8'd20},
		'{64'h0000_0080_0000_0000, {5'd8, 5'd1, 5'd1, 5'd16, 5'd2, 5'd0, 5'd0, 5'd0}, 4'd5,
		  64'h0640_0000_0000_0000, 32'd1, write_ms, 3'd6, 8'd0},
		'{64'h0000_0000_0000_3000, {5'd31, 5'd1, 5'd5, 5'd2, 5'd7, 5'd3, 5'd1, 5'd0}, 4'd7,
		  64'h0700_0000_0000_0000, 32'd8, write_na, 3'd7, 8'd10}
	};

	logic        clock;
	logic        rstn;
	logic        write_enabled;
	logic        job_valid;
	logic [63:0] job_base;
	logic [31:0] job_lines;
	logic [63:0] configure;
	logic [31:0] max_requests;
	logic        lane0_push;
	write_beat_t lane0_beat;
	logic        lane1_push;
	half_t       lane1_half;
	logic        cmd_alfull;
	logic        resp_valid;
	logic [31:0] resp_lines;
	logic        cmd_valid;
	logic [63:0] cmd_address;
	cmd_size_t   cmd_size;
	write_kind_t cmd_kind;
	order_code_t cmd_order;
	logic [7:0]  cmd_unit;
	half_t       cmd_half0;
	half_t       cmd_half1;
	logic        lanes_alfull;
	logic [31:0] done_lines;
	logic        job_done;

	logic [31:0] rng;
	int          cycle;
	int          row;
	int          errors;
	int          checks;
	int          jobs_failed;
	int          cmds_seen;
	int          outstanding;
	string       test_name;

	// expected commands in push order, responses waiting to be sent
	logic [63:0] exp_address [$];
	logic [31:0] exp_lines [$];
	half_t       exp_half0 [$];
	half_t       exp_half1 [$];
	int          resp_due [$];
	logic [31:0] resp_len [$];

	write_engine_top #(
		.fifo_depth   (fifo_depth   ),
		.fifo_headroom(fifo_headroom)
	) u_dut (
		.clock        (clock        ),
		.rstn         (rstn         ),
		.write_enabled(write_enabled),
		.job_valid    (job_valid    ),
		.job_base     (job_base     ),
		.job_lines    (job_lines    ),
		.configure    (configure    ),
		.max_requests (max_requests ),
		.lane0_push   (lane0_push   ),
		.lane0_beat   (lane0_beat   ),
		.lane1_push   (lane1_push   ),
		.lane1_half   (lane1_half   ),
		.cmd_alfull   (cmd_alfull   ),
		.resp_valid   (resp_valid   ),
		.resp_lines   (resp_lines   ),
		.cmd_valid    (cmd_valid    ),
		.cmd_address  (cmd_address  ),
		.cmd_size     (cmd_size     ),
		.cmd_kind     (cmd_kind     ),
		.cmd_order    (cmd_order    ),
		.cmd_unit     (cmd_unit     ),
		.cmd_half0    (cmd_half0    ),
		.cmd_half1    (cmd_half1    ),
		.lanes_alfull (lanes_alfull ),
		.done_lines   (done_lines   ),
		.job_done     (job_done     )
	);

	initial begin
		clock = 1'b0;
	end

	always #(period / 2) clock = ~clock;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic random_half(output half_t h);
		for (int i = 0; i < half_width / 32; i++) begin
			rng = xorshift(rng);
			h[i*32 +: 32] = rng;
		end
	endtask

	task automatic check_value(input string what, input logic [511:0] expected,
			input logic [511:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, expected,
				actual);
		end
	endtask

	////////////////////
	// command monitor
	////////////////////

	always @(negedge clock) begin
		logic [31:0] lines;
		if (rstn && resp_valid) begin
			outstanding--;
		end
		if (rstn && cmd_valid) begin
			cmds_seen++;
			outstanding++;
			if (exp_address.size() == 0) begin
				errors++;
				$display("%s: a command came out with no beat left to send", test_name);
			end else begin
				lines = exp_lines.pop_front();
				check_value("address", exp_address.pop_front(), cmd_address);
				check_value("size", lines * 128, cmd_size);
				check_value("half0", exp_half0.pop_front(), cmd_half0);
				check_value("half1", exp_half1.pop_front(), cmd_half1);
				check_value("kind", jobs[row].kind, cmd_kind);
				check_value("order", jobs[row].order, cmd_order);
				check_value("unit", 8'd3, cmd_unit);
				rng = xorshift(rng);
				resp_due.push_back(cycle + 1 + int'(rng % 4));
				resp_len.push_back(lines);
			end
			check_value("requests in flight within limit", 1,
				outstanding <= int'(jobs[row].max_requests));
		end
	end

	// response model, one answer per cycle in command order
	always @(posedge clock) begin
		cycle++;
		#1;
		if (resp_due.size() != 0 && resp_due[0] <= cycle) begin
			resp_valid = 1'b1;
			resp_lines = resp_len.pop_front();
			void'(resp_due.pop_front());
		end else begin
			resp_valid = 1'b0;
		end
	end

	////////////////////
	// job sequencing
	////////////////////

	task automatic apply_reset();
		@(posedge clock);
		#1;
		rstn       = 1'b0;
		job_valid  = 1'b0;
		lane0_push = 1'b0;
		lane1_push = 1'b0;
		configure  = '0;
		cmd_alfull = 1'b0;
		@(negedge clock);
		exp_address.delete();
		exp_lines.delete();
		exp_half0.delete();
		exp_half1.delete();
		resp_due.delete();
		resp_len.delete();
		cmds_seen   = 0;
		outstanding = 0;
		repeat (8) @(posedge clock);
		#1;
		rstn = 1'b1;
	endtask

	// configure is written once and then held at zero for the whole job
	task automatic start_job(input int r, output int total);
		total = 0;
		for (int i = 0; i < jobs[r].beats; i++) begin
			total += int'(jobs[r].lengths[i]);
		end
		@(posedge clock);
		#1;
		configure    = jobs[r].configure;
		max_requests = jobs[r].max_requests;
		cmd_alfull   = (jobs[r].stall != 0);
		repeat (2) @(posedge clock);
		#1;
		configure = '0;
		repeat (2) @(posedge clock);
		#1;
		job_valid = 1'b1;
		job_base  = jobs[r].base;
		job_lines = total;
		@(posedge clock);
		#1;
		job_valid = 1'b0;
	endtask

	task automatic push_beats(input int r);
		logic [63:0] beat_offset;
		half_t       h0;
		half_t       h1;
		int          i;
		beat_offset = '0;
		i = 0;
		while (i < jobs[r].beats) begin
			@(posedge clock);
			#1;
			lane0_push = 1'b0;
			lane1_push = 1'b0;
			if (!lanes_alfull) begin
				random_half(h0);
				random_half(h1);
				lane0_beat = '{data: h0, offset: beat_offset, lines: 32'(jobs[r].lengths[i])};
				lane1_half = h1;
				lane0_push = 1'b1;
				lane1_push = 1'b1;
				exp_address.push_back(jobs[r].base + beat_offset);
				exp_lines.push_back(32'(jobs[r].lengths[i]));
				exp_half0.push_back(h0);
				exp_half1.push_back(h1);
				beat_offset += 64'(jobs[r].lengths[i]) * 128;
				i++;
			end
		end
		@(posedge clock);
		#1;
		lane0_push = 1'b0;
		lane1_push = 1'b0;
	endtask

	// nothing is popped during the stall, so every pushed beat is still held
	task automatic release_stall(input int r);
		repeat (jobs[r].stall) @(posedge clock);
		#1;
		check_value("commands during stall", 0, cmds_seen);
		check_value("lanes almost full", exp_address.size() >= fifo_depth - fifo_headroom,
			lanes_alfull);
		cmd_alfull = 1'b0;
	endtask

	initial begin
		int total;
		int limit;
		int waited;
		int errors_before;
		rstn          = 1'b0;
		write_enabled = 1'b1;
		job_valid     = 1'b0;
		job_base      = '0;
		job_lines     = '0;
		configure     = '0;
		max_requests  = '0;
		lane0_push    = 1'b0;
		lane0_beat    = '0;
		lane1_push    = 1'b0;
		lane1_half    = '0;
		cmd_alfull    = 1'b0;
		resp_valid    = 1'b0;
		resp_lines    = '0;
		rng           = 32'h911a_698e;
		cycle         = 0;
		row           = 0;
		errors        = 0;
		checks        = 0;
		jobs_failed   = 0;
		for (int r = 0; r < num_jobs; r++) begin
			row           = r;
			test_name     = $sformatf("job%0d", r);
			errors_before = errors;
			apply_reset();
			start_job(r, total);
			fork
				push_beats(r);
				if (jobs[r].stall != 0) release_stall(r);
			join
			limit  = int'(jobs[r].beats) * 16 + 32;
			waited = 0;
			while (!job_done && waited < limit) begin
				@(negedge clock);
				waited++;
			end
			#1;
			if (!job_done) begin
				errors++;
				$display("%s: job_done did not rise within %0d cycles", test_name, limit);
			end
			check_value("done_lines", total, done_lines);
			check_value("commands", jobs[r].beats, cmds_seen);
			check_value("beats left over", 0, exp_address.size());
			check_value("requests in flight at end", 0, outstanding);
			if (errors == errors_before) begin
				$display("%s: passed, %0d commands, %0d lines", test_name, cmds_seen, total);
			end else begin
				jobs_failed++;
				$display("%s: failed with %0d errors", test_name, errors - errors_before);
			end
		end
		$display("jobs run %0d, jobs failed %0d, checks %0d, errors %0d", num_jobs,
			jobs_failed, checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// budget grows with the beats and stall cycles of every row
	initial begin
		longint budget;
		budget = 0;
		for (int r = 0; r < num_jobs; r++) begin
			budget += longint'(jobs[r].beats) * 24 + longint'(jobs[r].stall) + 80;
		end
		#(budget * period);
		$display("watchdog expired after %0d cycles, the run did not finish", budget);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: flist.f
write_bus_pkg.sv
write_stream_pkg.sv
beat_fifo.sv
write_engine_config.sv
write_stream_ctrl.sv
write_command_issue.sv
write_engine_top.sv
write_engine_assertions.sv
tb_write_engine.sv

// File: run.sh
#!/bin/sh
# build the write engine testbench with Verilator, run it, search the log
verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module tb_write_engine -o tb_write_engine &&
./obj_dir/tb_write_engine > sim.log 2>&1 ;
cat sim.log &&
grep -q "ALL TESTS PASSED" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
